// ==== design/udp_mem_defines.svh ====
`ifndef UDP_MEM_DEFINES_SVH
`define UDP_MEM_DEFINES_SVH

// ####################
// stream pacing
// ####################

`define WORD_GAP 4 // cycles between two words of a packet.

// ####################
// memory and opcodes
// ####################

`define RAM_AW 10

// header opcodes, in the top byte of the first word.
`define OP_WRITE 8'h80
`define OP_READ  8'h40

`endif

// ==== design/udp_mem_pkg.sv ====
package udp_mem_pkg;

`include "udp_mem_defines.svh"

    // first word of a packet.
    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  count; // data words for a write, words to return for a read.
        logic [15:0] rsvd;
    } cmd_hdr_s;

    // second word of a packet.
    typedef struct packed {
        logic [3:0]  rsvd;
        logic [27:0] addr;
    } cmd_addr_s;

    // one stream word, read as a header or as an address by its position.
    typedef union packed {
        cmd_hdr_s  hdr;
        cmd_addr_s addr;
    } cmd_word_u;

    typedef struct packed {
        logic [`RAM_AW-1:0] addr;
        logic [31:0]        data;
    } wr_req_s;

    typedef struct packed {
        logic [`RAM_AW-1:0] addr; // first word of the range.
        logic [7:0]         count;
    } rd_req_s;

endpackage

// ==== design/udp_cmd_source.sv ====
`timescale 1ns/10ps
`include "udp_mem_defines.svh"

module udp_cmd_source import udp_mem_pkg::*; (
    input  logic        gmii_rx_clk,
    input  logic        rstn,
    input  logic        wr_en,
    input  logic        rd_en,
    input  logic [7:0]  wr_num,
    input  logic [7:0]  rd_num,
    input  logic [27:0] wr_addr,
    input  logic [27:0] rd_addr,
    input  logic        tx_start_en,
    input  logic [31:0] udp_tx_data,
    output cmd_word_u   udp_rx_data,
    output logic        rec_en,
    output logic        rec_pkt_done,
    output logic        tx_req,
    output logic [31:0] rd_word,
    output logic        rd_word_stb,
    output logic        wr_done,
    output logic        rd_done
);

    localparam int GAP_W = $clog2(`WORD_GAP);
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`WORD_GAP - 1);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_WR      = 3'd1;
    localparam logic [2:0] S_RD_HDR  = 3'd2;
    localparam logic [2:0] S_RD_WAIT = 3'd3;
    localparam logic [2:0] S_RD_TX   = 3'd4;

    logic [1:0]       wr_sync;
    logic [1:0]       rd_sync;
    logic             wr_up;
    logic             rd_up;
    logic [2:0]       state;
    logic [GAP_W-1:0] gap_cnt;
    logic             gap_last;
    logic [8:0]       word_cnt; // header and address count as words 0 and 1.
    logic [7:0]       cmd_num;
    logic [27:0]      cmd_addr;
    logic             emit;
    cmd_word_u        next_word;

    // ####################
    // trigger edges
    // ####################

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wr_sync <= 2'b00;
            rd_sync <= 2'b00;
        end else begin
            wr_sync <= {wr_sync[0], wr_en};
            rd_sync <= {rd_sync[0], rd_en};
        end
    end

    assign wr_up = wr_sync[0] & ~wr_sync[1];
    assign rd_up = rd_sync[0] & ~rd_sync[1];

    // ####################
    // packet sequencer
    // ####################

    assign gap_last = (gap_cnt == GAP_LAST);
    assign emit     = gap_last && (state == S_WR || state == S_RD_HDR);

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state        <= S_IDLE;
            gap_cnt      <= '0;
            word_cnt     <= '0;
            rec_en       <= 1'b0;
            rec_pkt_done <= 1'b0;
            tx_req       <= 1'b0;
            wr_done      <= 1'b0;
            rd_done      <= 1'b0;
        end else begin
            rec_en       <= 1'b0;
            rec_pkt_done <= 1'b0;
            tx_req       <= 1'b0;
            wr_done      <= 1'b0;
            rd_done      <= 1'b0;
            if (state == S_IDLE || state == S_RD_WAIT || gap_last) begin
                gap_cnt <= '0;
            end else begin
                gap_cnt <= gap_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    word_cnt <= '0;
                    if (wr_up) begin // edges seen here only, so a busy source ignores them.
                        state <= S_WR;
                    end else if (rd_up) begin
                        state <= S_RD_HDR;
                    end
                end
                S_WR: begin
                    if (gap_last) begin
                        rec_en   <= 1'b1;
                        word_cnt <= word_cnt + 9'd1;
                        if (word_cnt == {1'b0, cmd_num} + 9'd1) begin
                            rec_pkt_done <= 1'b1;
                            wr_done      <= 1'b1;
                            state        <= S_IDLE;
                        end
                    end
                end
                S_RD_HDR: begin
                    if (gap_last) begin
                        rec_en   <= 1'b1;
                        word_cnt <= word_cnt + 9'd1;
                        if (word_cnt == 9'd1) begin
                            rec_pkt_done <= 1'b1;
                            word_cnt     <= '0;
                            if (cmd_num == 8'd0) begin
                                rd_done <= 1'b1; // nothing to fetch.
                                state   <= S_IDLE;
                            end else begin
                                state <= S_RD_WAIT;
                            end
                        end
                    end
                end
                S_RD_WAIT: begin
                    if (tx_start_en) begin
                        state <= S_RD_TX;
                    end
                end
                S_RD_TX: begin
                    if (gap_last) begin
                        tx_req   <= 1'b1;
                        word_cnt <= word_cnt + 9'd1;
                        if (word_cnt == {1'b0, cmd_num} - 9'd1) begin
                            rd_done <= 1'b1;
                            state   <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // command fields are frozen at the trigger so the inputs may change mid-packet.
    always_ff @(posedge gmii_rx_clk) begin
        if (state == S_IDLE && wr_up) begin
            cmd_num  <= wr_num;
            cmd_addr <= wr_addr;
        end else if (state == S_IDLE && rd_up) begin
            cmd_num  <= rd_num;
            cmd_addr <= rd_addr;
        end
    end

    always_comb begin
        if (word_cnt == 9'd0) begin
            next_word.hdr.opcode = (state == S_WR) ? `OP_WRITE : `OP_READ;
            next_word.hdr.count  = cmd_num;
            next_word.hdr.rsvd   = '0;
        end else if (word_cnt == 9'd1) begin
            next_word.addr.rsvd = '0;
            next_word.addr.addr = cmd_addr;
        end else begin
            next_word = cmd_word_u'(32'(word_cnt - 9'd2)); // data runs 0, 1, 2 and on.
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (emit) begin
            udp_rx_data <= next_word;
        end
    end

    // the responder's word is sampled in the tx_req cycle.
    assign rd_word     = udp_tx_data;
    assign rd_word_stb = tx_req;

    // the receive stream never runs inside the responder's transmit window.
    a_no_rx_tx_overlap: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        !(rec_en && tx_start_en));

    a_tx_req_in_window: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        tx_req |-> tx_start_en);

endmodule

// ==== design/udp_cmd_parser.sv ====
`timescale 1ns/10ps
`include "udp_mem_defines.svh"

module udp_cmd_parser import udp_mem_pkg::*; (
    input  logic      gmii_rx_clk,
    input  logic      rstn,
    input  cmd_word_u udp_rx_data,
    input  logic      rec_en,
    input  logic      rec_pkt_done,
    output wr_req_s   wr_req,
    output logic      wr_stb,
    output rd_req_s   rd_req,
    output logic      rd_stb
);

    localparam logic [1:0] POS_HDR  = 2'd0;
    localparam logic [1:0] POS_ADDR = 2'd1;
    localparam logic [1:0] POS_DATA = 2'd2;

    logic [1:0]         pos; // saturates on the data words.
    logic [7:0]         opcode;
    logic [7:0]         count;
    logic [`RAM_AW-1:0] cur_addr;

    // ####################
    // word position
    // ####################

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            pos    <= POS_HDR;
            opcode <= 8'h00;
            wr_stb <= 1'b0;
            rd_stb <= 1'b0;
        end else begin
            wr_stb <= 1'b0;
            rd_stb <= 1'b0;
            if (rec_en) begin
                if (rec_pkt_done) begin
                    pos <= POS_HDR;
                end else if (pos != POS_DATA) begin
                    pos <= pos + 2'd1;
                end
                case (pos)
                    POS_HDR:  opcode <= udp_rx_data.hdr.opcode;
                    POS_ADDR: rd_stb <= (opcode == `OP_READ);
                    default:  wr_stb <= (opcode == `OP_WRITE);
                endcase
            end
        end
    end

    // ####################
    // request payloads
    // ####################

    always_ff @(posedge gmii_rx_clk) begin
        if (rec_en) begin
            case (pos)
                POS_HDR: begin
                    count <= udp_rx_data.hdr.count;
                end
                POS_ADDR: begin
                    cur_addr     <= udp_rx_data.addr.addr[`RAM_AW-1:0];
                    rd_req.addr  <= udp_rx_data.addr.addr[`RAM_AW-1:0];
                    rd_req.count <= count;
                end
                default: begin
                    wr_req.addr <= cur_addr;
                    wr_req.data <= udp_rx_data;
                    cur_addr    <= cur_addr + 1'b1; // consecutive words land at consecutive addresses.
                end
            endcase
        end
    end

    a_known_opcode: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        (rec_en && pos == POS_HDR) |-> (udp_rx_data.hdr.opcode inside {`OP_WRITE, `OP_READ}));

endmodule

// ==== design/word_ram.sv ====
`timescale 1ns/10ps
`include "udp_mem_defines.svh"

module word_ram import udp_mem_pkg::*; (
    input  logic               gmii_rx_clk,
    input  logic               wr_stb,
    input  wr_req_s            wr_req,
    input  logic               rd_en,
    input  logic [`RAM_AW-1:0] rd_addr,
    output logic [31:0]        rd_data
);

    logic [31:0]        mem [2**`RAM_AW];
    logic [`RAM_AW-1:0] addr;

    // one address port, steered by whichever side is active.
    assign addr = wr_stb ? wr_req.addr : rd_addr;

    always_ff @(posedge gmii_rx_clk) begin
        if (wr_stb) begin
            mem[addr] <= wr_req.data;
        end else if (rd_en) begin
            rd_data <= mem[addr]; // holds until the next read.
        end
    end

    a_single_port: assert property (@(posedge gmii_rx_clk)
        !(wr_stb && rd_en));

endmodule

// ==== design/udp_rd_responder.sv ====
`timescale 1ns/10ps
`include "udp_mem_defines.svh"

module udp_rd_responder import udp_mem_pkg::*; (
    input  logic               gmii_rx_clk,
    input  logic               rstn,
    input  rd_req_s            rd_req,
    input  logic               rd_stb,
    input  logic               tx_req,
    input  logic [31:0]        ram_rd_data,
    output logic               ram_rd_en,
    output logic [`RAM_AW-1:0] ram_rd_addr,
    output logic               tx_start_en,
    output logic [31:0]        udp_tx_data
);

    logic [7:0] remain;
    logic       prefetch_pend; // first fetch issued, data not yet back.

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            ram_rd_en     <= 1'b0;
            ram_rd_addr   <= '0;
            tx_start_en   <= 1'b0;
            remain        <= 8'd0;
            prefetch_pend <= 1'b0;
        end else begin
            ram_rd_en     <= 1'b0;
            prefetch_pend <= 1'b0;
            if (rd_stb && rd_req.count != 8'd0) begin
                ram_rd_en     <= 1'b1;
                ram_rd_addr   <= rd_req.addr;
                remain        <= rd_req.count;
                prefetch_pend <= 1'b1;
            end else if (prefetch_pend) begin
                tx_start_en <= 1'b1; // RAM output is valid from the next cycle.
            end else if (tx_req && tx_start_en) begin
                remain <= remain - 8'd1;
                if (remain == 8'd1) begin
                    tx_start_en <= 1'b0;
                end else begin
                    ram_rd_en   <= 1'b1;
                    ram_rd_addr <= ram_rd_addr + 1'b1;
                end
            end
        end
    end

    // the RAM read register is the transmit word.
    assign udp_tx_data = ram_rd_data;

endmodule

// ==== design/udp_mem_top.sv ====
`timescale 1ns/10ps
`include "udp_mem_defines.svh"

module udp_mem_top import udp_mem_pkg::*; (
    input  logic        gmii_rx_clk,
    input  logic        rstn,
    input  logic        wr_en,
    input  logic        rd_en,
    input  logic [7:0]  wr_num,
    input  logic [7:0]  rd_num,
    input  logic [27:0] wr_addr,
    input  logic [27:0] rd_addr,
    output logic [31:0] rd_word,
    output logic        rd_word_stb,
    output logic        wr_done,
    output logic        rd_done
);

    cmd_word_u          udp_rx_data;
    logic               rec_en;
    logic               rec_pkt_done;
    logic               tx_req;
    logic               tx_start_en;
    logic [31:0]        udp_tx_data;
    wr_req_s            wr_req;
    logic               wr_stb;
    rd_req_s            rd_req;
    logic               rd_stb;
    logic               ram_rd_en;
    logic [`RAM_AW-1:0] ram_rd_addr;
    logic [31:0]        ram_rd_data;

    udp_cmd_source udp_cmd_source_i (
        .gmii_rx_clk  (gmii_rx_clk),
        .rstn         (rstn),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .wr_num       (wr_num),
        .rd_num       (rd_num),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .tx_start_en  (tx_start_en),
        .udp_tx_data  (udp_tx_data),
        .udp_rx_data  (udp_rx_data),
        .rec_en       (rec_en),
        .rec_pkt_done (rec_pkt_done),
        .tx_req       (tx_req),
        .rd_word      (rd_word),
        .rd_word_stb  (rd_word_stb),
        .wr_done      (wr_done),
        .rd_done      (rd_done)
    );

    udp_cmd_parser udp_cmd_parser_i (
        .gmii_rx_clk  (gmii_rx_clk),
        .rstn         (rstn),
        .udp_rx_data  (udp_rx_data),
        .rec_en       (rec_en),
        .rec_pkt_done (rec_pkt_done),
        .wr_req       (wr_req),
        .wr_stb       (wr_stb),
        .rd_req       (rd_req),
        .rd_stb       (rd_stb)
    );

    word_ram word_ram_i (
        .gmii_rx_clk (gmii_rx_clk),
        .wr_stb      (wr_stb),
        .wr_req      (wr_req),
        .rd_en       (ram_rd_en),
        .rd_addr     (ram_rd_addr),
        .rd_data     (ram_rd_data)
    );

    udp_rd_responder udp_rd_responder_i (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .rd_req      (rd_req),
        .rd_stb      (rd_stb),
        .tx_req      (tx_req),
        .ram_rd_data (ram_rd_data),
        .ram_rd_en   (ram_rd_en),
        .ram_rd_addr (ram_rd_addr),
        .tx_start_en (tx_start_en),
        .udp_tx_data (udp_tx_data)
    );

endmodule

// ==== bench/udp_mem_tb.sv ====
`timescale 1ns/10ps
`include "udp_mem_defines.svh"

module udp_mem_tb;

    logic        gmii_rx_clk;
    logic        rstn;
    logic        wr_en;
    logic        rd_en;
    logic [7:0]  wr_num;
    logic [7:0]  rd_num;
    logic [27:0] wr_addr;
    logic [27:0] rd_addr;
    logic [31:0] rd_word;
    logic        rd_word_stb;
    logic        wr_done;
    logic        rd_done;

    logic [31:0] ref_mem [2**`RAM_AW]; // expected RAM contents for the written ranges.

    udp_mem_top udp_mem_top_i (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .wr_num      (wr_num),
        .rd_num      (rd_num),
        .wr_addr     (wr_addr),
        .rd_addr     (rd_addr),
        .rd_word     (rd_word),
        .rd_word_stb (rd_word_stb),
        .wr_done     (wr_done),
        .rd_done     (rd_done)
    );

    always #50 gmii_rx_clk = ~gmii_rx_clk;

    // ####################
    // checks
    // ####################

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_done(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // no strobe or completion may show up while the DUT should be quiet.
    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge gmii_rx_clk);
            check_done("rd_word_stb", rd_word_stb, 1'b0);
            check_done("wr_done", wr_done, 1'b0);
            check_done("rd_done", rd_done, 1'b0);
        end
    endtask

    // ####################
    // commands
    // ####################

    task automatic do_write(input logic [27:0] addr, input logic [7:0] num, input bit retrigger);
        int cyc;
        int limit;
        bit done;
        logic [`RAM_AW-1:0] idx;
        wr_addr = addr;
        wr_num  = num;
        limit   = (num + 2) * `WORD_GAP + 30;
        cyc     = 0;
        done    = 1'b0;
        while (!done) begin
            // a retrigger pulse lands well inside the packet.
            wr_en = (cyc < 3) || (retrigger && cyc >= 12 && cyc < 15);
            @(negedge gmii_rx_clk);
            check_done("rd_word_stb", rd_word_stb, 1'b0);
            check_done("rd_done", rd_done, 1'b0);
            if (wr_done) begin
                done = 1'b1;
            end
            cyc++;
            if (!done && cyc > limit) begin
                abort_run($sformatf("timeout: no wr_done within %0d cycles of a write to %h",
                                    limit, addr));
            end
        end
        wr_en = 1'b0;
        for (int k = 0; k < num; k++) begin
            idx = addr[`RAM_AW-1:0] + `RAM_AW'(k);
            ref_mem[idx] = 32'(k); // the word at A+k holds k.
        end
    endtask

    task automatic do_read(input logic [27:0] addr, input logic [7:0] num);
        int cyc;
        int limit;
        bit done;
        logic [31:0] got_q [$];
        logic [`RAM_AW-1:0] idx;
        got_q.delete();
        rd_addr = addr;
        rd_num  = num;
        limit   = (num + 2) * `WORD_GAP + 40;
        cyc     = 0;
        done    = 1'b0;
        while (!done) begin
            rd_en = (cyc < 3);
            @(negedge gmii_rx_clk);
            check_done("wr_done", wr_done, 1'b0);
            if (rd_word_stb) begin
                got_q.push_back(rd_word);
            end
            if (rd_done) begin
                done = 1'b1; // the last word comes with rd_done.
            end
            cyc++;
            if (!done && cyc > limit) begin
                abort_run($sformatf("timeout: no rd_done within %0d cycles of a read at %h",
                                    limit, addr));
            end
        end
        rd_en = 1'b0;
        check_word("rd_word count", 32'(got_q.size()), 32'(num));
        for (int k = 0; k < num; k++) begin
            idx = addr[`RAM_AW-1:0] + `RAM_AW'(k);
            check_word($sformatf("rd_word[%0d]", k), got_q[k], ref_mem[idx]);
        end
    endtask

    // ####################
    // test sequence
    // ####################

    initial begin
        logic [27:0] a1;
        logic [27:0] a2;
        logic [7:0]  n1;
        logic [7:0]  n2;
        gmii_rx_clk = 1'b0;
        rstn        = 1'b0;
        wr_en       = 1'b0;
        rd_en       = 1'b0;
        wr_num      = 8'd0;
        rd_num      = 8'd0;
        wr_addr     = 28'd0;
        rd_addr     = 28'd0;
        void'($urandom(32'h95e3_4962));

        repeat (10) @(negedge gmii_rx_clk);
        rstn = 1'b1;
        idle_check(20);

        // write then read back the same range.
        do_write(28'h010, 8'd5, 1'b0);
        idle_check(12);
        do_read(28'h010, 8'd5);
        idle_check(12);

        // sub-range of the first block.
        do_read(28'h012, 8'd3);
        idle_check(12);

        // two disjoint random regions. The RAM ignores the upper address bits.
        a1 = {18'($urandom), 10'd200 + 10'($urandom % 100)};
        n1 = 8'(1 + $urandom % 8);
        a2 = {18'($urandom), 10'd600 + 10'($urandom % 100)};
        n2 = 8'(1 + $urandom % 8);
        do_write(a1, n1, 1'b0);
        idle_check(12);
        do_write(a2, n2, 1'b0);
        idle_check(12);
        do_read(a1, n1);
        idle_check(12);
        do_read(a2, n2);
        idle_check(12);

        // the later of two overlapping writes wins.
        do_write(28'h064, 8'd8, 1'b0);
        idle_check(12);
        do_write(28'h068, 8'd6, 1'b0);
        idle_check(12);
        do_read(28'h064, 8'd10);
        idle_check(12);

        // a second edge during a busy write must not start another packet.
        do_write(28'h12c, 8'd6, 1'b1);
        idle_check((6 + 2) * `WORD_GAP + 10);
        do_read(28'h12c, 8'd6);
        idle_check(12);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
design/udp_mem_pkg.sv
design/udp_cmd_source.sv
design/udp_cmd_parser.sv
design/word_ram.sv
design/udp_rd_responder.sv
design/udp_mem_top.sv
bench/udp_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module udp_mem_tb -f compile.f -o udp_mem_sim

# the testbench stops with a nonzero status on failure, so keep the log either way.
./obj_dir/udp_mem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
